// File: list.f
+incdir+.
isaPkg.sv
datapathPkg.sv
ctrlIf.sv
decode.sv
regFile.sv
alu.sv
dataMem.sv
fetch.sv
cpuTop.sv
cpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the CPU testbench with Verilator and runs it
# Exits with 0 only when the testbench reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps -f list.f --top-module cpuTb \
	-Mdir obj_dir -o simCpu
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/simCpu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1

// File: cpuTb.sv
// Testbench for the single-cycle CPU
// Loads a short program per table case during reset and checks the stores on the dmem ports
`default_nettype none
`include "cpuConsts.svh"

module cpuTb;
	timeunit 1ns;
	timeprecision 100ps;
	import isaPkg::*;
	import datapathPkg::*;

	typedef enum logic [2:0] {kAlu, kLdSt, kR0, kJ, kJr, kBgt, kNop} kind_e;

	// One table row where operand b is cut to 16 bits for immediate forms
	typedef struct packed {
		kind_e   kind;
		opcode_e op;
		word_t   a;
		word_t   b;
		logic    isImm;
	} case_t;

	localparam int clkPeriod = 8;
	localparam int resetCycles = 16;
	localparam int runLimit = 48;
	// End of program marker and the address a skipped store would hit
	localparam dmemAdrx_t markerAdrx = dmemAdrx_t'(`DMEM_DEPTH - 1);
	localparam dmemAdrx_t badAdrx = dmemAdrx_t'(`DMEM_DEPTH - 3);

	logic      clk;
	logic      reset;
	logic      imemWrEn;
	pcAdrx_t   imemAdrx;
	word_t     imemData;
	logic      dmemWrEn;
	dmemAdrx_t dmemAdrx;
	word_t     dmemWrData;

	case_t     cases[$];
	word_t     prog[$];
	dmemAdrx_t expAdrx[$];
	word_t     expData[$];
	int        errors;
	int        checks;
	int        numCases;
	word_t     lcgState;

	always #(clkPeriod / 2) clk = ~clk;

	cpuTop dut0 (.clk(clk), .reset(reset), .imemWrEn(imemWrEn), .imemAdrx(imemAdrx),
		.imemData(imemData), .dmemWrEn(dmemWrEn), .dmemAdrx(dmemAdrx),
		.dmemWrData(dmemWrData));

	function automatic word_t lcgNext();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	function automatic word_t sext16(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	// Expected ALU result per the ISA rules
	function automatic word_t refResult(opcode_e op, word_t a, word_t b);
		case (op)
			add: return a + b;
			sub: return a - b;
			opAnd: return a & b;
			opOr: return a | b;
			opXor: return a ^ b;
			slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			sll: return a << b[4:0];
			default: return '0;
		endcase
	endfunction

	function automatic word_t enc(opcode_e op, logic isImm, regAdrx_t rd, regAdrx_t rs1,
		logic [15:0] imm);
		return {op, isImm, rd, rs1, imm};
	endfunction

	// Any 32-bit constant in three steps with the high half pre-adjusted for the low sign
	function automatic void loadConst(regAdrx_t r, word_t v);
		logic [15:0] hiAdj;
		hiAdj = v[31:16] + {15'd0, v[15]};
		prog.push_back(enc(add, 1'b1, r, 5'd0, hiAdj));
		prog.push_back(enc(sll, 1'b1, r, r, 16'd16));
		prog.push_back(enc(add, 1'b1, r, r, v[15:0]));
	endfunction

	// sw with base r0 and the data register in the rs1 field
	function automatic void storeReg(regAdrx_t r, dmemAdrx_t adrx);
		prog.push_back(enc(sw, 1'b1, 5'd0, r, 16'(adrx)));
	endfunction

	function automatic void addExpected(dmemAdrx_t adrx, word_t data);
		expAdrx.push_back(adrx);
		expData.push_back(data);
	endfunction

	function automatic void addCase(kind_e kind, opcode_e op, word_t a, word_t b, logic isImm);
		case_t c;
		c.kind = kind;
		c.op = op;
		c.a = a;
		c.b = b;
		c.isImm = isImm;
		cases.push_back(c);
	endfunction

	// Program and expected stores for one case
	function automatic void buildProgram(int idx);
		case_t     c;
		dmemAdrx_t adrx;
		pcAdrx_t   target;
		word_t     bEff;
		c = cases[idx];
		adrx = dmemAdrx_t'(idx % 60);
		prog.delete();
		expAdrx.delete();
		expData.delete();
		case (c.kind)
			kAlu: begin
				bEff = c.isImm ? sext16(c.b[15:0]) : c.b;
				loadConst(5'd1, c.a);
				if (!c.isImm) begin
					loadConst(5'd2, c.b);
				end
				// Register form names r2 in imm[15:11]
				prog.push_back(enc(c.op, c.isImm, 5'd3, 5'd1,
					c.isImm ? c.b[15:0] : {5'd2, 11'd0}));
				storeReg(5'd3, adrx);
				addExpected(adrx, refResult(c.op, c.a, bEff));
			end
			kLdSt: begin
				loadConst(5'd1, c.a);
				storeReg(5'd1, adrx);
				// Read back into r4 and store the copy one word higher
				prog.push_back(enc(lw, 1'b1, 5'd4, 5'd0, 16'(adrx)));
				storeReg(5'd4, adrx + 1'b1);
				addExpected(adrx, c.a);
				addExpected(adrx + 1'b1, c.a);
			end
			kR0: begin
				// Leading sw sits at address 0 while reset is held
				storeReg(5'd0, adrx);
				loadConst(5'd0, c.a);
				storeReg(5'd0, adrx);
				addExpected(adrx, '0);
				addExpected(adrx, '0);
			end
			kJ: begin
				loadConst(5'd1, c.a);
				target = pcAdrx_t'(prog.size() + 2);
				prog.push_back(enc(j, 1'b1, 5'd0, 5'd0, 16'(target)));
				storeReg(5'd1, badAdrx);
				storeReg(5'd1, adrx);
				addExpected(adrx, c.a);
			end
			kJr: begin
				loadConst(5'd1, c.a);
				// r5 gets the target and jr skips one store
				target = pcAdrx_t'(prog.size() + 3);
				prog.push_back(enc(add, 1'b1, 5'd5, 5'd0, 16'(target)));
				prog.push_back(enc(jr, 1'b0, 5'd0, 5'd5, 16'd0));
				storeReg(5'd1, badAdrx);
				storeReg(5'd1, adrx);
				addExpected(adrx, c.a);
			end
			kBgt: begin
				loadConst(5'd1, c.a);
				loadConst(5'd2, c.b);
				target = pcAdrx_t'(prog.size() + 2);
				// rs1 is r1 and rs0 is r2 in imm[15:11] with the target in the low bits
				prog.push_back(enc(bgt, 1'b0, 5'd0, 5'd1,
					{5'd2, {(11 - `PC_WIDTH){1'b0}}, target}));
				storeReg(5'd1, adrx);
				// Store survives only when the branch falls through
				if (!($signed(c.a) > $signed(c.b))) begin
					addExpected(adrx, c.a);
				end
			end
			default: begin
				repeat (3) begin
					prog.push_back(enc(nop, 1'b0, 5'd0, 5'd0, 16'd0));
				end
			end
		endcase
		storeReg(5'd0, markerAdrx);
		target = pcAdrx_t'(prog.size());
		prog.push_back(enc(j, 1'b1, 5'd0, 5'd0, 16'(target)));
	endfunction

	task automatic runCase(int idx);
		int   seen;
		logic done;
		buildProgram(idx);
		// Program loads while reset is held and nop padding fills the rest
		reset = 1'b1;
		imemWrEn = 1'b1;
		for (int i = 0; i < resetCycles; i++) begin
			imemAdrx = pcAdrx_t'(i);
			imemData = (i < prog.size()) ? prog[i] : '0;
			@(negedge clk);
			checks++;
			assert (dmemWrEn == 1'b0) else begin
				errors++;
				$display("Error: case %0d raised a store during reset", idx);
			end
			@(posedge clk);
			#1;
		end
		reset = 1'b0;
		imemWrEn = 1'b0;
		seen = 0;
		done = 1'b0;
		// Stores up to the marker are sampled mid-cycle
		for (int cyc = 0; cyc < runLimit && !done; cyc++) begin
			@(negedge clk);
			if (dmemWrEn && dmemAdrx == markerAdrx) begin
				done = 1'b1;
			end else if (dmemWrEn && seen < expAdrx.size()) begin
				checks++;
				assert (dmemAdrx == expAdrx[seen] && dmemWrData == expData[seen]) else begin
					errors++;
					$display("Fail %0t: case %0d store %0d at %0d data %h, expected %0d data %h",
						$time, idx, seen, dmemAdrx, dmemWrData, expAdrx[seen], expData[seen]);
				end
				seen++;
			end else begin
				assert (!dmemWrEn) else begin
					errors++;
					$display("Error: case %0d made an extra store at address %0d", idx, dmemAdrx);
					seen++;
				end
			end
		end
		checks++;
		assert (done) else begin
			errors++;
			$display("Error: case %0d never reached its end marker store", idx);
		end
		checks++;
		assert (seen == expAdrx.size()) else begin
			errors++;
			$display("Fail %0t: case %0d made %0d stores, expected %0d",
				$time, idx, seen, expAdrx.size());
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		word_t ra;
		word_t rb;
		clk = 1'b0;
		reset = 1'b1;
		imemWrEn = 1'b0;
		imemAdrx = '0;
		imemData = '0;
		errors = 0;
		checks = 0;
		lcgState = 32'd10;
		// Register forms at the operand edges
		addCase(kAlu, add, 32'h7fffffff, 32'd1, 1'b0);
		addCase(kAlu, sub, 32'd0, 32'd1, 1'b0);
		addCase(kAlu, opAnd, 32'hffffffff, 32'h0f0f00ff, 1'b0);
		addCase(kAlu, opOr, 32'h80000000, 32'd0, 1'b0);
		addCase(kAlu, opXor, 32'hffffffff, 32'h80000000, 1'b0);
		addCase(kAlu, slt, 32'h80000000, 32'd1, 1'b0);
		addCase(kAlu, slt, 32'd1, 32'hffffffff, 1'b0);
		addCase(kAlu, sll, 32'hffffffff, 32'd31, 1'b0);
		// Immediate forms with several negative immediates
		addCase(kAlu, add, 32'd5, 32'h0000ffff, 1'b1);
		addCase(kAlu, sub, 32'h80000000, 32'h00008000, 1'b1);
		addCase(kAlu, opAnd, 32'h12345678, 32'h0000f0f0, 1'b1);
		addCase(kAlu, opOr, 32'd0, 32'h00008001, 1'b1);
		addCase(kAlu, opXor, 32'hffffffff, 32'h00007fff, 1'b1);
		addCase(kAlu, slt, 32'hfffffffe, 32'h0000ffff, 1'b1);
		addCase(kAlu, sll, 32'd1, 32'd31, 1'b1);
		// LCG operands for add through sll in both forms
		for (int k = 0; k < 7; k++) begin
			ra = lcgNext();
			rb = lcgNext();
			addCase(kAlu, opcode_e'(5'(k + 1)), ra, rb, 1'b0);
			addCase(kAlu, opcode_e'(5'(k + 1)), rb, ra, 1'b1);
		end
		addCase(kLdSt, nop, 32'hdeadbeef, 32'd0, 1'b0);
		addCase(kR0, nop, 32'h00001234, 32'd0, 1'b0);
		addCase(kJ, nop, 32'h0000abcd, 32'd0, 1'b0);
		addCase(kJr, nop, 32'h87654321, 32'd0, 1'b0);
		// bgt at the signed edges is taken only for the first and last
		addCase(kBgt, nop, 32'd1, 32'hffffffff, 1'b0);
		addCase(kBgt, nop, 32'h80000000, 32'd0, 1'b0);
		addCase(kBgt, nop, 32'd5, 32'd5, 1'b0);
		addCase(kBgt, nop, 32'h7fffffff, 32'h80000000, 1'b0);
		addCase(kNop, nop, 32'd0, 32'd0, 1'b0);
		numCases = cases.size();
		@(posedge clk);
		#1;
		for (int idx = 0; idx < numCases; idx++) begin
			runCase(idx);
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// Reset time plus a run budget for every case
	initial begin
		wait (numCases > 0);
		#(numCases * (resetCycles + 50) * clkPeriod);
		$display("Error: watchdog timeout, the test programs did not finish in time");
		$display("Verification failed");
		$finish;
	end
endmodule

`default_nettype wire

// File: cpuTop.sv
// Top level of the single-cycle teaching CPU
// Program loads through the imem port in reset and stores show on the dmem ports
`default_nettype none
`include "cpuConsts.svh"

module cpuTop (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   imemWrEn,
	input  datapathPkg::pcAdrx_t   imemAdrx,
	input  datapathPkg::word_t     imemData,
	output logic                   dmemWrEn,
	output datapathPkg::dmemAdrx_t dmemAdrx,
	output datapathPkg::word_t     dmemWrData
);
	import isaPkg::*;
	import datapathPkg::*;

	word_t    instruction;
	regAdrx_t rdAdrx;
	regAdrx_t rs1Adrx;
	regAdrx_t rs0Adrx;
	word_t    immediate;
	word_t    rs0Data;
	word_t    rs1Data;
	word_t    busB;
	word_t    aluResult;
	word_t    dmemReadData;
	logic     nFlag;
	aluCtl_e  aluCtl;

	ctrlIf ctrl ();

	// ALU op taken straight off the control bundle
	assign aluCtl = ctrl.aluCtl;

	fetch fetchInst (.clk(clk), .reset(reset), .imemWrEn(imemWrEn), .imemAdrx(imemAdrx),
		.imemData(imemData), .nFlag(nFlag), .instruction(instruction), .ctrl(ctrl.pc));

	decode decodeInst (.instruction(instruction), .nFlag(nFlag), .jrTarget(rs1Data),
		.rdAdrx(rdAdrx), .rs1Adrx(rs1Adrx), .rs0Adrx(rs0Adrx), .immediate(immediate),
		.ctrl(ctrl.decoder));

	regFile regFileInst (.clk(clk), .reset(reset), .rs0Adrx(rs0Adrx), .rs1Adrx(rs1Adrx),
		.rdAdrx(rdAdrx), .writeData(aluResult), .dmemData(dmemReadData),
		.immediate(immediate), .rs0Data(rs0Data), .rs1Data(rs1Data), .busB(busB),
		.ctrl(ctrl.datapath));

	// Bus A is always read port 1
	alu aluInst (.busA(rs1Data), .busB(busB), .aluCtl(aluCtl), .result(aluResult),
		.nFlag(nFlag));

	dataMem dataMemInst (.clk(clk), .reset(reset), .adrx(dmemAdrx), .writeData(dmemWrData),
		.readData(dmemReadData), .ctrl(ctrl.mem));

	// Store ports mirror the data memory write and stay quiet while reset is high
	assign dmemWrEn = ctrl.dmemWriteEn && !reset;
	assign dmemAdrx = aluResult[`DMEM_ADRX_WIDTH-1:0];
	// sw routes its rs1 field register onto read port 0
	assign dmemWrData = rs0Data;
endmodule

`default_nettype wire

// File: fetch.sv
// Program counter and instruction memory with its load port
// Program is loaded during reset, then one instruction per clock
`default_nettype none
`include "cpuConsts.svh"

module fetch (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 imemWrEn,
	input  datapathPkg::pcAdrx_t imemAdrx,
	input  datapathPkg::word_t   imemData,
	input  logic                 nFlag,
	output datapathPkg::word_t   instruction,
	ctrlIf.pc                    ctrl
);
	import datapathPkg::*;

	word_t   imem [`IMEM_DEPTH];
	pcAdrx_t pc;
	pcAdrx_t nextPc;
	logic    takeDest;

	// Load port is live only while reset is high
	always_ff @(posedge clk) begin
		if (reset && imemWrEn) begin
			imem[imemAdrx] <= imemData;
		end
	end

	// Jump always redirects, branch only when taken
	assign takeDest = ctrl.jump || (ctrl.branch && nFlag);
	assign nextPc = takeDest ? ctrl.pcDest : pc + 1'b1;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else begin
			pc <= nextPc;
		end
	end

	// Combinational read of the current instruction
	assign instruction = imem[pc];
endmodule

`default_nettype wire

// File: dataMem.sv
// Word-addressed data memory, 64 words
// Combinational read, write on the clock edge, cleared by a sweep in reset
`default_nettype none
`include "cpuConsts.svh"

module dataMem (
	input  logic                   clk,
	input  logic                   reset,
	input  datapathPkg::dmemAdrx_t adrx,
	input  datapathPkg::word_t     writeData,
	output datapathPkg::word_t     readData,
	ctrlIf.mem                     ctrl
);
	import datapathPkg::*;

	word_t mem [`DMEM_DEPTH];
	// Selects a group of four words
	logic [`DMEM_ADRX_WIDTH-3:0] clearIdx;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < 4; k++) begin
				mem[{clearIdx, k[1:0]}] <= '0;
			end
			// Wraps, so any 16 reset cycles reach every group
			clearIdx <= clearIdx + 1'b1;
		end else begin
			clearIdx <= '0;
			if (ctrl.dmemWriteEn) begin
				mem[adrx] <= writeData;
			end
		end
	end

	assign readData = mem[adrx];
endmodule

`default_nettype wire

// File: alu.sv
// Eight-operation ALU for the single-cycle CPU
// Combinational, with a signed negative flag for bgt
`default_nettype none
`include "cpuConsts.svh"

module alu (
	input  datapathPkg::word_t busA,
	input  datapathPkg::word_t busB,
	input  isaPkg::aluCtl_e    aluCtl,
	output datapathPkg::word_t result,
	output logic               nFlag
);
	import isaPkg::*;
	import datapathPkg::*;

	// One extra bit so the sign survives overflow
	logic [`WORD_WIDTH:0] diff;

	assign diff = {busA[`WORD_WIDTH-1], busA} - {busB[`WORD_WIDTH-1], busB};
	// True sign of busA - busB whatever the operation
	assign nFlag = diff[`WORD_WIDTH];

	always_comb begin
		case (aluCtl)
			aluAdd: result = busA + busB;
			aluSub: result = busA - busB;
			aluAnd: result = busA & busB;
			aluOr: result = busA | busB;
			aluXor: result = busA ^ busB;
			// Signed less-than is the sign of the wide difference
			aluSlt: result = word_t'(nFlag);
			aluSll: result = busA << busB[4:0];
			default: result = '0;
		endcase
	end
endmodule

`default_nettype wire

// File: regFile.sv
// 32 by 32 register file with two read ports and one write port
// Also holds the write-back select and the operand B select
`default_nettype none
`include "cpuConsts.svh"

module regFile (
	input  logic                  clk,
	input  logic                  reset,
	input  datapathPkg::regAdrx_t rs0Adrx,
	input  datapathPkg::regAdrx_t rs1Adrx,
	input  datapathPkg::regAdrx_t rdAdrx,
	// ALU result for write-back
	input  datapathPkg::word_t    writeData,
	// Data memory read for lw write-back
	input  datapathPkg::word_t    dmemData,
	input  datapathPkg::word_t    immediate,
	output datapathPkg::word_t    rs0Data,
	output datapathPkg::word_t    rs1Data,
	output datapathPkg::word_t    busB,
	ctrlIf.datapath               ctrl
);
	import datapathPkg::*;

	word_t regs [`NUM_REGS];
	word_t rdData;

	assign rdData = ctrl.dmemResultSel ? dmemData : writeData;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.rfWriteEn && (rdAdrx != '0)) begin
			regs[rdAdrx] <= rdData;
		end
	end

	// Register 0 always reads zero
	assign rs0Data = (rs0Adrx == '0) ? '0 : regs[rs0Adrx];
	assign rs1Data = (rs1Adrx == '0) ? '0 : regs[rs1Adrx];

	assign busB = ctrl.aluBusBSel ? immediate : rs0Data;
endmodule

`default_nettype wire

// File: decode.sv
// Instruction decoder for the single-cycle CPU
// Slices the instruction fields and drives all control through ctrlIf
`default_nettype none
`include "cpuConsts.svh"

module decode (
	input  datapathPkg::word_t    instruction,
	input  logic                  nFlag,
	input  datapathPkg::word_t    jrTarget,
	output datapathPkg::regAdrx_t rdAdrx,
	output datapathPkg::regAdrx_t rs1Adrx,
	output datapathPkg::regAdrx_t rs0Adrx,
	output datapathPkg::word_t    immediate,
	ctrlIf.decoder                ctrl
);
	import isaPkg::*;
	import datapathPkg::*;

	instr_t   instr;
	regAdrx_t rs0Field;

	assign instr = instr_t'(instruction);
	// Second source register shares bits with the immediate
	assign rs0Field = instr.imm[15:11];
	assign rdAdrx = instr.rd;

	// Sign extend to the full word
	assign immediate = {{(`WORD_WIDTH - 16){instr.imm[15]}}, instr.imm};

	always_comb begin
		// Nop behavior unless the opcode says otherwise
		ctrl.rfWriteEn = 1'b0;
		ctrl.aluCtl = aluPass;
		ctrl.aluBusBSel = instr.isImm;
		ctrl.dmemResultSel = 1'b0;
		ctrl.dmemWriteEn = 1'b0;
		ctrl.branch = 1'b0;
		ctrl.jump = 1'b0;
		ctrl.pcDest = instr.imm[`PC_WIDTH-1:0];
		rs1Adrx = instr.rs1;
		rs0Adrx = rs0Field;

		case (instr.opcode)
			add, sub, opAnd, opOr, opXor, slt, sll: begin
				ctrl.rfWriteEn = 1'b1;
				// Low opcode bits are the ALU code
				ctrl.aluCtl = aluCtl_e'(instr.opcode[2:0]);
			end
			lw: begin
				// Address is rs1 plus immediate
				ctrl.rfWriteEn = 1'b1;
				ctrl.aluCtl = aluAdd;
				ctrl.aluBusBSel = 1'b1;
				ctrl.dmemResultSel = 1'b1;
			end
			sw: begin
				ctrl.dmemWriteEn = 1'b1;
				ctrl.aluCtl = aluAdd;
				ctrl.aluBusBSel = 1'b1;
				// Base register sits in the rd field and feeds bus A
				rs1Adrx = instr.rd;
				// Store data from the rs1 field, read on port 0
				rs0Adrx = instr.rs1;
			end
			j: begin
				ctrl.jump = 1'b1;
			end
			jr: begin
				ctrl.jump = 1'b1;
				ctrl.pcDest = jrTarget[`PC_WIDTH-1:0];
			end
			bgt: begin
				// Swap ports so the ALU forms reg[rs0] - reg[rs1]
				rs1Adrx = rs0Field;
				rs0Adrx = instr.rs1;
				ctrl.aluCtl = aluSub;
				ctrl.aluBusBSel = 1'b0;
				// Negative difference means rs1 greater than rs0
				ctrl.branch = nFlag;
			end
			default: begin
			end
		endcase
	end
endmodule

`default_nettype wire

// File: ctrlIf.sv
// Decoded control bundle from the decoder to the data path blocks
// One instance lives in the CPU top and each block takes its modport
`default_nettype none

interface ctrlIf;
	import isaPkg::*;
	import datapathPkg::*;

	logic    rfWriteEn;
	aluCtl_e aluCtl;
	// High selects the immediate as ALU operand B
	logic    aluBusBSel;
	logic    dmemResultSel;
	logic    dmemWriteEn;
	logic    branch;
	logic    jump;
	pcAdrx_t pcDest;

	modport decoder (output rfWriteEn, aluCtl, aluBusBSel, dmemResultSel,
		dmemWriteEn, branch, jump, pcDest);
	modport datapath (input rfWriteEn, aluBusBSel, dmemResultSel);
	modport mem (input dmemWriteEn);
	modport pc (input branch, jump, pcDest);
endinterface

`default_nettype wire

// File: datapathPkg.sv
// Data path types for the teaching CPU
// Words, register indices and memory word addresses
`default_nettype none
`include "cpuConsts.svh"

package datapathPkg;

	// Data or instruction word
	typedef logic [`WORD_WIDTH-1:0] word_t;

	// Register file index
	typedef logic [`REG_ADRX_WIDTH-1:0] regAdrx_t;

	// Instruction memory word address, also the PC
	typedef logic [`PC_WIDTH-1:0] pcAdrx_t;

	// Data memory word address
	typedef logic [`DMEM_ADRX_WIDTH-1:0] dmemAdrx_t;

endpackage

`default_nettype wire

// File: isaPkg.sv
// Instruction set types for the teaching CPU
// Opcodes, ALU operations and the instruction word layout
`default_nettype none
`include "cpuConsts.svh"

package isaPkg;

	// Opcode field, bits 31 to 27
	typedef enum logic [4:0] {
		nop = 5'd0,
		add,
		sub,
		opAnd,
		opOr,
		opXor,
		slt,
		sll,
		lw,
		sw,
		j,
		jr,
		bgt
	} opcode_e;

	// ALU operation select
	// add through sll share their low opcode bits with these codes
	typedef enum logic [2:0] {
		aluPass = 3'd0,
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll
	} aluCtl_e;

	// Raw immediate field before sign extension
	typedef logic [15:0] imm_t;

	// Instruction word layout
	// Second source register overlays imm[15:11]
	typedef struct packed {
		opcode_e                      opcode;
		logic                         isImm;
		logic [`REG_ADRX_WIDTH-1:0]   rd;
		logic [`REG_ADRX_WIDTH-1:0]   rs1;
		imm_t                         imm;
	} instr_t;

endpackage

`default_nettype wire

// File: cpuConsts.svh
// Widths and memory depths for the single-cycle CPU
// Include in any package or module that sizes a vector or a memory
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data path and instruction word width
`define WORD_WIDTH 32

// Register file index width and register count
`define REG_ADRX_WIDTH 5
`define NUM_REGS (1 << `REG_ADRX_WIDTH)

// Instruction memory word address and depth
`define PC_WIDTH 7
`define IMEM_DEPTH (1 << `PC_WIDTH)

// Data memory word address and depth
`define DMEM_ADRX_WIDTH 6
`define DMEM_DEPTH (1 << `DMEM_ADRX_WIDTH)

`endif
